/* common/video_settings.svh */
// frame geometry and raster timing constants, included by the packages and modules that need them
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// clk cycles per pixel tick
`define VID_PHASES 4

// pentagon frame, pixel ticks per line and lines per frame
`define VID_HPERIOD 448
`define VID_VPERIOD 320

// tv horizontal sync and blank
`define VID_HSYNC_BEG 10
`define VID_HSYNC_END 43
`define VID_HBLNK_END 88

// vga horizontal sync and blank, repeated at half line
`define VID_HSYNCV_BEG 5
`define VID_HSYNCV_END 31
`define VID_HBLNKV_END 44

// vertical sync and blank, in lines
`define VID_VSYNC_BEG 8
`define VID_VSYNC_END 11
`define VID_VBLNK_END 32

// zx interrupt position and length in pixel ticks
`define VID_HINT_BEG 2
`define VID_VINT_BEG 0
`define VID_INT_LEN 32

// fetch runs ahead of the pixel window by this many ticks
`define VID_GO_LEAD 8

`endif

/* common/raster_pkg.sv */
// raster counter types and the position, sync and control bundles shared by the video blocks
`default_nettype none

package raster_pkg;

	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	typedef struct packed {
		hcount_t hcount;
		vcount_t vcount;
	} raster_pos_t;

	// all active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic csync;
	} sync_t;

	typedef struct packed {
		logic hpix;
		logic vpix;
		logic hvpix;
		logic tv_blank;
		logic vga_line;
		logic line_start;
		logic frame_start;
		logic tv_pix_start;
		logic vga_pix_start;
		logic pix_start;
		logic video_go;
	} video_ctrl_t;

endpackage

`default_nettype wire

/* common/mode_pkg.sv */
// video mode encoding and the per-mode active window table, used by the mode decoder and testbench
`default_nettype none

`include "video_settings.svh"

package mode_pkg;

	import raster_pkg::*;

	typedef enum logic [1:0] {
		MODE_ZX      = 2'd0,
		MODE_320X200 = 2'd1,
		MODE_360X288 = 2'd2
	} mode_t;

	typedef struct packed {
		hcount_t hpix_beg;
		hcount_t hpix_end;
		vcount_t vpix_beg;
		vcount_t vpix_end;
		hcount_t go_beg;
		hcount_t go_end;
	} window_t;

	// window row for a mode, unknown codes fall back to zx
	function automatic window_t mode_window(input mode_t m);
		window_t w;
		case (m)
			MODE_320X200:
			begin
				w.hpix_beg = 9'd108;
				w.hpix_end = 9'd428;
				w.vpix_beg = 9'd76;
				w.vpix_end = 9'd276;
			end
			MODE_360X288:
			begin
				w.hpix_beg = 9'd88;
				w.hpix_end = 9'd448;
				w.vpix_beg = 9'd32;
				w.vpix_end = 9'd320;
			end
			default:
			begin
				w.hpix_beg = 9'd140;
				w.hpix_end = 9'd396;
				w.vpix_beg = 9'd80;
				w.vpix_end = 9'd272;
			end
		endcase
		w.go_beg = w.hpix_beg - hcount_t'(`VID_GO_LEAD);
		w.go_end = w.hpix_end - hcount_t'(`VID_GO_LEAD);
		return w;
	endfunction

endpackage

`default_nettype wire

/* rtl/clock_phase.sv */
// divides clk into the pixel tick and phase-0 strobes that pace the whole raster
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module clock_phase (
	input  wire  clk,
	input  wire  rst_n,
	output logic pix_tick,
	output logic ph0
);

	localparam int PH_W = $clog2(`VID_PHASES);
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(`VID_PHASES - 1);

	logic [PH_W-1:0] phase;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= '0;
		end
		else if (phase == PH_LAST)
		begin
			phase <= '0;
		end
		else
		begin
			phase <= phase + 1'b1;
		end
	end

	// tick on the last phase so counters step at the end of a pixel
	assign pix_tick = (phase == PH_LAST);
	assign ph0      = (phase == '0);

endmodule

`default_nettype wire

/* video_sync/mode_decode.sv */
// holds the requested video mode and switches the active window only at frame start
`timescale 1ns/1ps
`default_nettype none

module mode_decode (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                pix_tick,
	input  wire                frame_start,
	input  wire                mode_we,
	input  mode_pkg::mode_t    mode,
	output mode_pkg::window_t  window
);

	import mode_pkg::*;

	mode_t   pending;
	logic    frame_edge;

	assign frame_edge = pix_tick && frame_start;

	// last write before the frame boundary wins
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pending <= MODE_ZX;
		end
		else if (mode_we)
		begin
			pending <= mode;
		end
	end

	// reload only between frames so a frame never mixes two windows
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			window <= mode_window(MODE_ZX);
		end
		else if (frame_edge)
		begin
			window <= mode_window(pending);
		end
	end

endmodule

`default_nettype wire

/* video_sync/video_sync.sv */
// pentagon raster counters with tv/vga sync, blanking and window strobe decode
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_sync (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  pix_tick,
	input  wire                  ph0,
	input  mode_pkg::window_t    window,
	output raster_pkg::raster_pos_t pos,
	output raster_pkg::sync_t    sync,
	output raster_pkg::video_ctrl_t ctrl,
	output logic                 int_start
);

	import raster_pkg::*;

	localparam hcount_t H_LAST       = hcount_t'(`VID_HPERIOD - 1);
	localparam hcount_t H_HALF       = hcount_t'(`VID_HPERIOD / 2);
	localparam vcount_t V_LAST       = vcount_t'(`VID_VPERIOD - 1);
	localparam hcount_t HSYNC_BEG    = hcount_t'(`VID_HSYNC_BEG);
	localparam hcount_t HSYNC_END    = hcount_t'(`VID_HSYNC_END);
	localparam hcount_t HBLNK_END    = hcount_t'(`VID_HBLNK_END);
	localparam hcount_t HSYNCV_BEG   = hcount_t'(`VID_HSYNCV_BEG);
	localparam hcount_t HSYNCV_END   = hcount_t'(`VID_HSYNCV_END);
	localparam hcount_t HBLNKV_END   = hcount_t'(`VID_HBLNKV_END);
	localparam vcount_t VSYNC_BEG    = vcount_t'(`VID_VSYNC_BEG);
	localparam vcount_t VSYNC_END    = vcount_t'(`VID_VSYNC_END);
	localparam vcount_t VBLNK_END    = vcount_t'(`VID_VBLNK_END);
	localparam hcount_t HINT_BEG     = hcount_t'(`VID_HINT_BEG);
	localparam vcount_t VINT_BEG     = vcount_t'(`VID_VINT_BEG);

	hcount_t hcount;
	vcount_t vcount;
	logic    hs;
	logic    hs_vga;
	logic    hb;
	logic    vs;
	logic    vb;
	logic    hpix;
	logic    vpix;
	logic    line_end;

	assign line_end = (hcount == H_LAST);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hcount <= '0;
			vcount <= '0;
		end
		else if (pix_tick)
		begin
			hcount <= line_end ? '0 : hcount + 1'b1;
			if (line_end)
			begin
				vcount <= (vcount == V_LAST) ? '0 : vcount + 1'b1;
			end
		end
	end

	assign pos.hcount = hcount;
	assign pos.vcount = vcount;

	// blanking starts at count 0 on both axes
	assign hs     = (hcount >= HSYNC_BEG) && (hcount < HSYNC_END);
	assign hb     = (hcount < HBLNK_END);
	assign vs     = (vcount >= VSYNC_BEG) && (vcount < VSYNC_END);
	assign vb     = (vcount < VBLNK_END);

	// vga runs two lines per tv line
	assign hs_vga = ((hcount >= HSYNCV_BEG) && (hcount < HSYNCV_END)) ||
			((hcount >= HSYNCV_BEG + H_HALF) && (hcount < HSYNCV_END + H_HALF));

	assign hpix = (hcount >= window.hpix_beg) && (hcount < window.hpix_end);
	assign vpix = (vcount >= window.vpix_beg) && (vcount < window.vpix_end);

	always_comb
	begin
		ctrl.hpix          = hpix;
		ctrl.vpix          = vpix;
		ctrl.hvpix         = hpix && vpix;
		ctrl.tv_blank      = hb || vb;
		ctrl.vga_line      = (hcount >= H_HALF);
		ctrl.line_start    = line_end;
		ctrl.frame_start   = line_end && (vcount == V_LAST);
		ctrl.tv_pix_start  = (hcount == HBLNK_END - 1'b1);
		ctrl.vga_pix_start = ph0 && ((hcount == HBLNKV_END - 1'b1) ||
				(hcount == HBLNKV_END + H_HALF - 1'b1));
		ctrl.pix_start     = (hcount == hcount_t'(window.hpix_beg - 1'b1));
		ctrl.video_go      = (hcount >= window.go_beg) && (hcount < window.go_end) && vpix;
	end

	assign int_start = (hcount == HINT_BEG) && (vcount == VINT_BEG);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync <= '1;
		end
		else
		begin
			sync.hsync <= ~hs_vga;
			sync.vsync <= ~vs;
			sync.csync <= ~(hs ^ vs);
		end
	end

endmodule

`default_nettype wire

/* rtl/int_gen.sv */
// stretches the frame interrupt position into the active-low zx INT pulse
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module int_gen (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  pix_tick,
	input  wire  int_start,
	output logic int_n
);

	localparam int CNT_W = $clog2(`VID_INT_LEN + 1);
	localparam logic [CNT_W-1:0] INT_LEN = CNT_W'(`VID_INT_LEN);

	logic [CNT_W-1:0] remain;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			remain <= '0;
			int_n  <= 1'b1;
		end
		else if (pix_tick)
		begin
			if (int_start)
			begin
				remain <= INT_LEN;
			end
			else if (remain != '0)
			begin
				remain <= remain - 1'b1;
			end
			// release on the tick that empties the counter
			int_n <= ~(int_start || (remain > CNT_W'(1)));
		end
	end

endmodule

`default_nettype wire

/* rtl/video_top.sv */
// video timing top, joins the phase divider, mode decoder, raster generator and INT generator
`timescale 1ns/1ps
`default_nettype none

module video_top (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     mode_we,
	input  mode_pkg::mode_t         mode,
	output raster_pkg::raster_pos_t pos,
	output raster_pkg::sync_t       sync,
	output raster_pkg::video_ctrl_t ctrl,
	output logic                    pix_tick,
	output logic                    int_n
);

	import mode_pkg::*;

	logic    ph0;
	logic    int_start;
	window_t window;

	clock_phase u_clock_phase (
		.clk      (clk),
		.rst_n    (rst_n),
		.pix_tick (pix_tick),
		.ph0      (ph0)
	);

	// frame_start comes back from the raster to time the window swap
	mode_decode u_mode_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.pix_tick    (pix_tick),
		.frame_start (ctrl.frame_start),
		.mode_we     (mode_we),
		.mode        (mode),
		.window      (window)
	);

	video_sync u_video_sync (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_tick  (pix_tick),
		.ph0       (ph0),
		.window    (window),
		.pos       (pos),
		.sync      (sync),
		.ctrl      (ctrl),
		.int_start (int_start)
	);

	int_gen u_int_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_tick  (pix_tick),
		.int_start (int_start),
		.int_n     (int_n)
	);

endmodule

`default_nettype wire

/* verification/video_sync_properties.sv */
// concurrent checks on the raster generator, bound into every video_sync instance
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_sync_properties (
	input wire                     clk,
	input wire                     rst_n,
	input wire                     pix_tick,
	input wire                     ph0,
	input raster_pkg::raster_pos_t pos,
	input raster_pkg::video_ctrl_t ctrl
);

	import raster_pkg::*;

	int fail_count;

	initial
	begin
		fail_count = 0;
	end

	// exactly one tick in every four clks
	tick_period: assert property (@(posedge clk) disable iff (!rst_n)
		pix_tick |=> !pix_tick ##1 !pix_tick ##1 !pix_tick ##1 pix_tick)
	else
	begin
		$error("pix_tick is not one clk in four");
		fail_count++;
	end

	count_range: assert property (@(posedge clk) disable iff (!rst_n)
		(pos.hcount < hcount_t'(`VID_HPERIOD)) && (pos.vcount < vcount_t'(`VID_VPERIOD)))
	else
	begin
		$error("raster counter out of range");
		fail_count++;
	end

	vga_start_on_ph0: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.vga_pix_start |-> ph0)
	else
	begin
		$error("vga_pix_start outside phase 0");
		fail_count++;
	end

	frame_on_line: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.frame_start |-> ctrl.line_start)
	else
	begin
		$error("frame_start without line_start");
		fail_count++;
	end

endmodule

bind video_sync video_sync_properties u_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.pix_tick (pix_tick),
	.ph0      (ph0),
	.pos      (pos),
	.ctrl     (ctrl)
);

`default_nettype wire

/* verification/tb_clock.sv */
// free-running clock source for the video timing testbench, one instance drives the DUT clk
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2.0) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* verification/video_tb.sv */
// testbench top for video_top, runs the raster against a reference model with random mode writes
`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_tb;

	import raster_pkg::*;
	import mode_pkg::*;

	localparam int FRAME_CLKS = `VID_HPERIOD * `VID_VPERIOD * `VID_PHASES;
	localparam int LINE_CLKS  = `VID_HPERIOD * `VID_PHASES;
	localparam int HALF       = `VID_HPERIOD / 2;

	// hpix_beg, hpix_end, vpix_beg, vpix_end per mode
	localparam int WIN_TABLE [3][4] = '{
		'{140, 396, 80, 272},
		'{108, 428, 76, 276},
		'{88, 448, 32, 320}
	};

	logic        clk;
	logic        rst_n;
	logic        mode_we;
	mode_t       mode;
	raster_pos_t pos;
	sync_t       sync;
	video_ctrl_t ctrl;
	logic        pix_tick;
	logic        int_n;

	// model state, stepped on posedge and compared on negedge
	raster_pos_t exp_pos;
	sync_t       exp_sync;
	window_t     exp_win;
	mode_t       exp_pending;
	int          exp_phase;
	int          int_left;

	tb_clock u_clock (
		.clk (clk)
	);

	video_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.mode_we  (mode_we),
		.mode     (mode),
		.pos      (pos),
		.sync     (sync),
		.ctrl     (ctrl),
		.pix_tick (pix_tick),
		.int_n    (int_n)
	);

	function automatic window_t window_for_mode(input mode_t m);
		window_t w;
		w.hpix_beg = hcount_t'(WIN_TABLE[m][0]);
		w.hpix_end = hcount_t'(WIN_TABLE[m][1]);
		w.vpix_beg = vcount_t'(WIN_TABLE[m][2]);
		w.vpix_end = vcount_t'(WIN_TABLE[m][3]);
		w.go_beg   = hcount_t'(WIN_TABLE[m][0] - `VID_GO_LEAD);
		w.go_end   = hcount_t'(WIN_TABLE[m][1] - `VID_GO_LEAD);
		return w;
	endfunction

	function automatic video_ctrl_t ctrl_from_pos(input raster_pos_t p, input window_t w,
			input logic at_ph0);
		video_ctrl_t c;
		int          h;
		int          v;
		h = p.hcount;
		v = p.vcount;
		c.hpix          = (h >= int'(w.hpix_beg)) && (h < int'(w.hpix_end));
		c.vpix          = (v >= int'(w.vpix_beg)) && (v < int'(w.vpix_end));
		c.hvpix         = c.hpix && c.vpix;
		c.tv_blank      = (h < `VID_HBLNK_END) || (v < `VID_VBLNK_END);
		c.vga_line      = (h >= HALF);
		c.line_start    = (h == `VID_HPERIOD - 1);
		c.frame_start   = c.line_start && (v == `VID_VPERIOD - 1);
		c.tv_pix_start  = (h == `VID_HBLNK_END - 1);
		c.vga_pix_start = at_ph0 && ((h == `VID_HBLNKV_END - 1) ||
				(h == `VID_HBLNKV_END + HALF - 1));
		c.pix_start     = (h == int'(w.hpix_beg) - 1);
		c.video_go      = (h >= int'(w.go_beg)) && (h < int'(w.go_end)) && c.vpix;
		return c;
	endfunction

	function automatic sync_t sync_from_pos(input raster_pos_t p);
		sync_t s;
		int    h;
		int    v;
		logic  tv_hs;
		logic  vga_hs;
		logic  tv_vs;
		h = p.hcount;
		v = p.vcount;
		tv_hs  = (h >= `VID_HSYNC_BEG) && (h < `VID_HSYNC_END);
		vga_hs = ((h >= `VID_HSYNCV_BEG) && (h < `VID_HSYNCV_END)) ||
				((h >= `VID_HSYNCV_BEG + HALF) && (h < `VID_HSYNCV_END + HALF));
		tv_vs  = (v >= `VID_VSYNC_BEG) && (v < `VID_VSYNC_END);
		s.hsync = !vga_hs;
		s.vsync = !tv_vs;
		s.csync = !(tv_hs ^ tv_vs);
		return s;
	endfunction

	function automatic raster_pos_t next_pos(input raster_pos_t p);
		raster_pos_t n;
		n = p;
		if (p.hcount == `VID_HPERIOD - 1)
		begin
			n.hcount = '0;
			n.vcount = (p.vcount == `VID_VPERIOD - 1) ? '0 : p.vcount + 1'b1;
		end
		else
		begin
			n.hcount = p.hcount + 1'b1;
		end
		return n;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp)
		else
			fail_run($sformatf("CHECK FAILED: %s expected %0h got %0h", name, exp, got));
	endtask

	task automatic wait_frame_end();
		@(negedge clk);
		while (!(pix_tick && ctrl.frame_start))
			@(negedge clk);
	endtask

	// random writes at random gaps, all well inside one frame
	task automatic write_round(input int count, input mode_t last);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			gap = $urandom_range(30000, 1000);
			repeat (gap) @(posedge clk);
			#1;
			mode_we = 1'b1;
			mode    = (i == count - 1) ? last : mode_t'($urandom_range(2));
			@(posedge clk);
			#1;
			mode_we = 1'b0;
			// idle bus value has to be ignored
			mode    = mode_t'($urandom_range(2));
		end
	endtask

	always @(posedge clk)
	begin
		if (rst_n)
		begin
			exp_sync = sync_from_pos(exp_pos);
			if (exp_phase == `VID_PHASES - 1)
			begin
				if ((exp_pos.hcount == `VID_HINT_BEG) && (exp_pos.vcount == `VID_VINT_BEG))
					int_left = `VID_INT_LEN;
				else if (int_left > 0)
					int_left--;
				if ((exp_pos.hcount == `VID_HPERIOD - 1) && (exp_pos.vcount == `VID_VPERIOD - 1))
					exp_win = window_for_mode(exp_pending);
				exp_pos = next_pos(exp_pos);
			end
			if (mode_we)
				exp_pending = mode;
			exp_phase = (exp_phase + 1) % `VID_PHASES;
		end
	end

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			check_value("pix_tick", pix_tick, exp_phase == `VID_PHASES - 1);
			check_value("pos", pos, exp_pos);
			check_value("sync", sync, exp_sync);
			check_value("ctrl", ctrl, ctrl_from_pos(exp_pos, exp_win, exp_phase == 0));
			check_value("int_n", int_n, int_left == 0);
		end
	end

	always @(posedge clk)
	begin
		if (uut.u_video_sync.u_props.fail_count != 0)
			fail_run("a concurrent assertion on video_sync failed");
	end

	initial
	begin
		repeat (3 * FRAME_CLKS) @(posedge clk);
		fail_run("watchdog expired before the tests finished");
	end

	initial
	begin
		void'($urandom(9034));
		rst_n       = 1'b0;
		mode_we     = 1'b0;
		mode        = MODE_ZX;
		exp_pos     = '0;
		exp_sync    = '1;
		exp_win     = window_for_mode(MODE_ZX);
		exp_pending = MODE_ZX;
		exp_phase   = 0;
		int_left    = 0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// first frame keeps zx whatever is written
		write_round(4, mode_t'(1 + $urandom_range(1)));
		wait_frame_end();
		write_round(4, mode_t'($urandom_range(2)));
		wait_frame_end();
		repeat (8 * LINE_CLKS) @(posedge clk);
		if (uut.u_video_sync.u_props.fail_count == 0)
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
		begin
			fail_run("concurrent assertions on video_sync failed");
		end
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/raster_pkg.sv
common/mode_pkg.sv
rtl/clock_phase.sv
video_sync/mode_decode.sv
video_sync/video_sync.sv
rtl/int_gen.sv
rtl/video_top.sv
verification/video_sync_properties.sv
verification/tb_clock.sv
verification/video_tb.sv

/* Bender.yml */
package:
  name: video_timing

export_include_dirs:
  - common

sources:
  - common/raster_pkg.sv
  - common/mode_pkg.sv
  - rtl/clock_phase.sv
  - video_sync/mode_decode.sv
  - video_sync/video_sync.sv
  - rtl/int_gen.sv
  - rtl/video_top.sv
  - target: test
    files:
      - verification/video_sync_properties.sv
      - verification/tb_clock.sv
      - verification/video_tb.sv
